// File: common/core_pkg.sv
// Execution pipeline shared definitions

package core_pkg;

  // ############################################################
  // Widths
  // ############################################################

  localparam int xlen = 64;
  localparam int reg_addr_w = 5;
  localparam int n_regs = 1 << reg_addr_w;
  localparam int ram_addr_w = 8;
  localparam int ram_depth = 1 << ram_addr_w;

  // Doublewords are 8 bytes, so the RAM index starts at byte address bit 3.
  localparam int ram_addr_lsb = 3;

  // Shift amounts use the low 6 bits of the second operand.
  localparam int shamt_w = 6;

  // ############################################################
  // Types
  // ############################################################

  typedef logic [xlen-1:0] reg_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [ram_addr_w-1:0] ram_addr_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_load,
    op_store
  } alu_op_t;

  // Bit positions in wr_ctrl_t. A store writes no register and has both bits low.
  localparam int exe_to_reg = 0;
  localparam int mem_to_reg = 1;

  typedef logic [1:0] wr_ctrl_t;

endpackage

// File: logic/reg_file.sv
// Integer register file
`timescale 1ns/10ps

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::reg_addr_t wr_addr,
  input  logic                wr_ena,
  input  core_pkg::reg_t      wr_data,
  output core_pkg::reg_t      rs1_data,
  output core_pkg::reg_t      rs2_data
);

  // Register zero has no storage.
  core_pkg::reg_t regs [1:core_pkg::n_regs-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < core_pkg::n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads are combinational. A write in the same cycle is seen through forwarding.
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// File: logic/data_ram.sv
// Doubleword data memory
`timescale 1ns/10ps

module data_ram (
  input  logic                clk,
  input  core_pkg::ram_addr_t addr,
  input  logic                wr_ena,
  input  core_pkg::reg_t      wr_data,
  output core_pkg::reg_t      rd_data
);

  core_pkg::reg_t mem [core_pkg::ram_depth];

  // The memory starts out cleared, so loads of unwritten words give zero.
  initial begin
    for (int i = 0; i < core_pkg::ram_depth; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (wr_ena) begin
      mem[addr] <= wr_data;
    end
  end

  // Registered read. The word shows up in the cycle after the address.
  always_ff @(posedge clk) begin
    rd_data <= mem[addr];
  end

endmodule

// File: pipe/forward.sv
// Operand forwarding and load-use detection
`timescale 1ns/10ps

module forward (
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::reg_addr_t mem_reg_wr_addr,
  input  logic                mem_reg_wr_ena,
  input  core_pkg::reg_addr_t wb_reg_wr_addr,
  input  logic                wb_reg_wr_ena,
  input  core_pkg::reg_t      mem_ex_data,
  input  core_pkg::reg_t      wb_ex_data,
  input  core_pkg::reg_t      wb_mem_data,
  input  core_pkg::wr_ctrl_t  mem_reg_wr_ctrl,
  input  core_pkg::wr_ctrl_t  wb_reg_wr_ctrl,
  input  core_pkg::reg_t      now_op1,
  input  core_pkg::reg_t      now_op2,
  output core_pkg::reg_t      rs1_forward,
  output core_pkg::reg_t      rs2_forward,
  output logic                load_use
);

  // A source matches a pending write unless it is register zero.
  function automatic logic addr_hit(
    input core_pkg::reg_addr_t src,
    input core_pkg::reg_addr_t dst,
    input logic                ena
  );
    return (src == dst) && ena && (src != '0);
  endfunction

  logic op1_mem_ex, op1_mem_ld, op1_wb_ex, op1_wb_ld;
  logic op2_mem_ex, op2_mem_ld, op2_wb_ex, op2_wb_ld;

  assign op1_mem_ex = addr_hit(rs1_addr, mem_reg_wr_addr, mem_reg_wr_ena)
                      && mem_reg_wr_ctrl[core_pkg::exe_to_reg];
  assign op1_mem_ld = addr_hit(rs1_addr, mem_reg_wr_addr, mem_reg_wr_ena)
                      && mem_reg_wr_ctrl[core_pkg::mem_to_reg];
  assign op1_wb_ex  = addr_hit(rs1_addr, wb_reg_wr_addr, wb_reg_wr_ena)
                      && wb_reg_wr_ctrl[core_pkg::exe_to_reg];
  assign op1_wb_ld  = addr_hit(rs1_addr, wb_reg_wr_addr, wb_reg_wr_ena)
                      && wb_reg_wr_ctrl[core_pkg::mem_to_reg];

  assign op2_mem_ex = addr_hit(rs2_addr, mem_reg_wr_addr, mem_reg_wr_ena)
                      && mem_reg_wr_ctrl[core_pkg::exe_to_reg];
  assign op2_mem_ld = addr_hit(rs2_addr, mem_reg_wr_addr, mem_reg_wr_ena)
                      && mem_reg_wr_ctrl[core_pkg::mem_to_reg];
  assign op2_wb_ex  = addr_hit(rs2_addr, wb_reg_wr_addr, wb_reg_wr_ena)
                      && wb_reg_wr_ctrl[core_pkg::exe_to_reg];
  assign op2_wb_ld  = addr_hit(rs2_addr, wb_reg_wr_addr, wb_reg_wr_ena)
                      && wb_reg_wr_ctrl[core_pkg::mem_to_reg];

  // Newest result wins.
  assign rs1_forward = op1_mem_ex ? mem_ex_data :
                       op1_wb_ex  ? wb_ex_data  :
                       op1_wb_ld  ? wb_mem_data :
                       now_op1;

  assign rs2_forward = op2_mem_ex ? mem_ex_data :
                       op2_wb_ex  ? wb_ex_data  :
                       op2_wb_ld  ? wb_mem_data :
                       now_op2;

  // Load data is not ready until writeback, so a memory-stage load match stalls.
  assign load_use = op1_mem_ld || op2_mem_ld;

endmodule

// File: pipe/alu.sv
// Integer ALU
`timescale 1ns/10ps

module alu (
  input  core_pkg::alu_op_t op,
  input  core_pkg::reg_t    a,
  input  core_pkg::reg_t    b,
  output core_pkg::reg_t    result
);

  logic [core_pkg::shamt_w-1:0] shamt;
  logic                         less;

  assign shamt = b[core_pkg::shamt_w-1:0];
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      core_pkg::op_add: begin
        result = a + b;
      end
      core_pkg::op_sub: begin
        result = a - b;
      end
      core_pkg::op_and: begin
        result = a & b;
      end
      core_pkg::op_or: begin
        result = a | b;
      end
      core_pkg::op_xor: begin
        result = a ^ b;
      end
      core_pkg::op_sll: begin
        result = a << shamt;
      end
      core_pkg::op_srl: begin
        result = a >> shamt;
      end
      core_pkg::op_slt: begin
        result = {{(core_pkg::xlen-1){1'b0}}, less};
      end
      // Loads and stores need only the byte address.
      core_pkg::op_load, core_pkg::op_store: begin
        result = a + b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: pipe/exec_stage.sv
// Execute stage
`timescale 1ns/10ps

module exec_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue,
  input  core_pkg::alu_op_t   issue_op,
  input  core_pkg::reg_addr_t issue_rd,
  input  core_pkg::reg_addr_t issue_rs1,
  input  core_pkg::reg_addr_t issue_rs2,
  input  core_pkg::reg_t      issue_imm,
  input  logic                issue_use_imm,
  input  core_pkg::reg_t      rf_rs1_data,
  input  core_pkg::reg_t      rf_rs2_data,
  input  core_pkg::reg_addr_t wb_rd,
  input  logic                wb_wr_ena,
  input  core_pkg::wr_ctrl_t  wb_wr_ctrl,
  input  core_pkg::reg_t      wb_ex_data,
  input  core_pkg::reg_t      wb_mem_data,
  output logic                issue_stall,
  output core_pkg::reg_addr_t rf_rs1_addr,
  output core_pkg::reg_addr_t rf_rs2_addr,
  output logic                mem_valid,
  output core_pkg::reg_addr_t mem_rd,
  output core_pkg::wr_ctrl_t  mem_wr_ctrl,
  output core_pkg::reg_t      mem_ex_data,
  output logic                mem_store,
  output core_pkg::reg_t      mem_store_data,
  output core_pkg::ram_addr_t mem_addr
);

  logic                ex_valid;
  core_pkg::alu_op_t   ex_op;
  core_pkg::reg_addr_t ex_rd;
  core_pkg::reg_addr_t ex_rs1;
  core_pkg::reg_addr_t ex_rs2;
  core_pkg::reg_t      ex_imm;
  logic                ex_use_imm;
  logic                ex_rs2_read;
  logic                load_use;
  logic                advance;
  core_pkg::wr_ctrl_t  ex_wr_ctrl;
  core_pkg::reg_t      rs1_fwd;
  core_pkg::reg_t      rs2_fwd;
  core_pkg::reg_t      op_b;
  core_pkg::reg_t      alu_result;

  // ############################################################
  // Execute register
  // ############################################################

  // The register holds its instruction while a load-use stall is in effect.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else if (!load_use) begin
      ex_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !load_use) begin
      ex_op      <= issue_op;
      ex_rd      <= issue_rd;
      ex_rs1     <= issue_rs1;
      ex_rs2     <= issue_rs2;
      ex_imm     <= issue_imm;
      ex_use_imm <= issue_use_imm;
    end
  end

  assign issue_stall = load_use;
  assign advance     = ex_valid && !load_use;

  // Only sources that are really read take part in forwarding and hazards.
  // A store reads rs2 as its data even though the offset is an immediate.
  assign ex_rs2_read = !ex_use_imm || (ex_op == core_pkg::op_store);
  assign rf_rs1_addr = ex_valid ? ex_rs1 : '0;
  assign rf_rs2_addr = (ex_valid && ex_rs2_read) ? ex_rs2 : '0;

  forward u_forward (
    .rs1_addr        (rf_rs1_addr),
    .rs2_addr        (rf_rs2_addr),
    .mem_reg_wr_addr (mem_rd),
    .mem_reg_wr_ena  (mem_valid),
    .wb_reg_wr_addr  (wb_rd),
    .wb_reg_wr_ena   (wb_wr_ena),
    .mem_ex_data     (mem_ex_data),
    .wb_ex_data      (wb_ex_data),
    .wb_mem_data     (wb_mem_data),
    .mem_reg_wr_ctrl (mem_wr_ctrl),
    .wb_reg_wr_ctrl  (wb_wr_ctrl),
    .now_op1         (rf_rs1_data),
    .now_op2         (rf_rs2_data),
    .rs1_forward     (rs1_fwd),
    .rs2_forward     (rs2_fwd),
    .load_use        (load_use)
  );

  assign op_b = ex_use_imm ? ex_imm : rs2_fwd;

  alu u_alu (
    .op     (ex_op),
    .a      (rs1_fwd),
    .b      (op_b),
    .result (alu_result)
  );

  always_comb begin
    ex_wr_ctrl = '0;
    case (ex_op)
      core_pkg::op_load: begin
        ex_wr_ctrl[core_pkg::mem_to_reg] = 1'b1;
      end
      core_pkg::op_store: begin
        ex_wr_ctrl = '0;
      end
      default: begin
        ex_wr_ctrl[core_pkg::exe_to_reg] = 1'b1;
      end
    endcase
  end

  // ############################################################
  // Memory register
  // ############################################################

  // A stall sends a bubble with no write and no store.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_valid   <= 1'b0;
      mem_wr_ctrl <= '0;
      mem_store   <= 1'b0;
    end else begin
      mem_valid   <= advance;
      mem_wr_ctrl <= advance ? ex_wr_ctrl : '0;
      mem_store   <= advance && (ex_op == core_pkg::op_store);
    end
  end

  always_ff @(posedge clk) begin
    mem_rd         <= ex_rd;
    mem_ex_data    <= alu_result;
    mem_store_data <= rs2_fwd;
    mem_addr       <= alu_result[core_pkg::ram_addr_lsb +: core_pkg::ram_addr_w];
  end

endmodule

// File: pipe/mem_stage.sv
// Memory and writeback stages
`timescale 1ns/10ps

module mem_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_valid,
  input  core_pkg::reg_addr_t mem_rd,
  input  core_pkg::wr_ctrl_t  mem_wr_ctrl,
  input  core_pkg::reg_t      mem_ex_data,
  input  logic                mem_store,
  input  core_pkg::reg_t      mem_store_data,
  input  core_pkg::ram_addr_t mem_addr,
  output core_pkg::reg_addr_t wb_rd,
  output logic                wb_wr_ena,
  output core_pkg::wr_ctrl_t  wb_wr_ctrl,
  output core_pkg::reg_t      wb_ex_data,
  output core_pkg::reg_t      wb_mem_data,
  output logic                retire,
  output logic                retire_we,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::reg_t      retire_data
);

  logic wb_valid;

  // Load data comes out of the RAM register one cycle later, in writeback.
  data_ram u_data_ram (
    .clk     (clk),
    .addr    (mem_addr),
    .wr_ena  (mem_store),
    .wr_data (mem_store_data),
    .rd_data (wb_mem_data)
  );

  // ############################################################
  // Writeback register
  // ############################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid   <= 1'b0;
      wb_wr_ena  <= 1'b0;
      wb_wr_ctrl <= '0;
    end else begin
      wb_valid   <= mem_valid;
      wb_wr_ena  <= mem_valid && (mem_wr_ctrl != '0) && (mem_rd != '0);
      wb_wr_ctrl <= mem_wr_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd      <= mem_rd;
    wb_ex_data <= mem_ex_data;
  end

  // Every instruction retires once. Stores and writes to register zero retire with no write.
  assign retire      = wb_valid;
  assign retire_we   = wb_wr_ena;
  assign retire_rd   = wb_rd;
  assign retire_data = wb_wr_ctrl[core_pkg::mem_to_reg] ? wb_mem_data : wb_ex_data;

endmodule

// File: pipe/exec_pipe.sv
// Integer execution pipeline top
`timescale 1ns/10ps

module exec_pipe (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue,
  input  core_pkg::alu_op_t   issue_op,
  input  core_pkg::reg_addr_t issue_rd,
  input  core_pkg::reg_addr_t issue_rs1,
  input  core_pkg::reg_addr_t issue_rs2,
  input  core_pkg::reg_t      issue_imm,
  input  logic                issue_use_imm,
  output logic                issue_stall,
  output logic                retire,
  output logic                retire_we,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::reg_t      retire_data
);

  core_pkg::reg_addr_t rf_rs1_addr;
  core_pkg::reg_addr_t rf_rs2_addr;
  core_pkg::reg_t      rf_rs1_data;
  core_pkg::reg_t      rf_rs2_data;

  logic                mem_valid;
  core_pkg::reg_addr_t mem_rd;
  core_pkg::wr_ctrl_t  mem_wr_ctrl;
  core_pkg::reg_t      mem_ex_data;
  logic                mem_store;
  core_pkg::reg_t      mem_store_data;
  core_pkg::ram_addr_t mem_addr;

  core_pkg::reg_addr_t wb_rd;
  logic                wb_wr_ena;
  core_pkg::wr_ctrl_t  wb_wr_ctrl;
  core_pkg::reg_t      wb_ex_data;
  core_pkg::reg_t      wb_mem_data;

  exec_stage u_exec_stage (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue          (issue),
    .issue_op       (issue_op),
    .issue_rd       (issue_rd),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_imm      (issue_imm),
    .issue_use_imm  (issue_use_imm),
    .rf_rs1_data    (rf_rs1_data),
    .rf_rs2_data    (rf_rs2_data),
    .wb_rd          (wb_rd),
    .wb_wr_ena      (wb_wr_ena),
    .wb_wr_ctrl     (wb_wr_ctrl),
    .wb_ex_data     (wb_ex_data),
    .wb_mem_data    (wb_mem_data),
    .issue_stall    (issue_stall),
    .rf_rs1_addr    (rf_rs1_addr),
    .rf_rs2_addr    (rf_rs2_addr),
    .mem_valid      (mem_valid),
    .mem_rd         (mem_rd),
    .mem_wr_ctrl    (mem_wr_ctrl),
    .mem_ex_data    (mem_ex_data),
    .mem_store      (mem_store),
    .mem_store_data (mem_store_data),
    .mem_addr       (mem_addr)
  );

  // The register file is written with the retired value at the end of writeback.
  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rf_rs1_addr),
    .rs2_addr (rf_rs2_addr),
    .wr_addr  (wb_rd),
    .wr_ena   (wb_wr_ena),
    .wr_data  (retire_data),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  mem_stage u_mem_stage (
    .clk            (clk),
    .arst_n         (arst_n),
    .mem_valid      (mem_valid),
    .mem_rd         (mem_rd),
    .mem_wr_ctrl    (mem_wr_ctrl),
    .mem_ex_data    (mem_ex_data),
    .mem_store      (mem_store),
    .mem_store_data (mem_store_data),
    .mem_addr       (mem_addr),
    .wb_rd          (wb_rd),
    .wb_wr_ena      (wb_wr_ena),
    .wb_wr_ctrl     (wb_wr_ctrl),
    .wb_ex_data     (wb_ex_data),
    .wb_mem_data    (wb_mem_data),
    .retire         (retire),
    .retire_we      (retire_we),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

endmodule

// File: test/tb_model.svh
// Pipeline reference model
`ifndef tb_model_svh
`define tb_model_svh

// Architectural state, updated in program order as instructions are issued.
core_pkg::reg_t      ref_regs [32];
core_pkg::reg_t      ref_mem [core_pkg::ram_depth];

// Expected retire records, oldest first.
core_pkg::reg_addr_t exp_rd_q [$];
logic                exp_we_q [$];
core_pkg::reg_t      exp_data_q [$];
int                  exp_cycle_q [$];

int                  exp_stalls;
int                  last_mem_cycle;
core_pkg::reg_addr_t last_load_rd;

task automatic reset_model();
  for (int i = 0; i < 32; i++) begin
    ref_regs[i] = '0;
  end
  for (int i = 0; i < core_pkg::ram_depth; i++) begin
    ref_mem[i] = '0;
  end
  exp_stalls     = 0;
  last_mem_cycle = -10;
  last_load_rd   = '0;
endtask

function automatic core_pkg::reg_t alu_value(
  input core_pkg::alu_op_t op,
  input core_pkg::reg_t    a,
  input core_pkg::reg_t    b
);
  case (op)
    core_pkg::op_sub: return a - b;
    core_pkg::op_and: return a & b;
    core_pkg::op_or:  return a | b;
    core_pkg::op_xor: return a ^ b;
    core_pkg::op_sll: return a << b[5:0];
    core_pkg::op_srl: return a >> b[5:0];
    core_pkg::op_slt: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    default:          return a + b;
  endcase
endfunction

// Executes one instruction and queues what it must retire, and when.
task automatic predict_retire(
  input core_pkg::alu_op_t   op,
  input core_pkg::reg_addr_t rd,
  input core_pkg::reg_addr_t rs1,
  input core_pkg::reg_addr_t rs2,
  input core_pkg::reg_t      imm,
  input logic                use_imm,
  input int                  issue_cycle
);
  core_pkg::reg_t a;
  core_pkg::reg_t b;
  core_pkg::reg_t sum;
  core_pkg::reg_t value;
  logic           reads_rs2;
  logic           writes;
  int             stall;
  a         = ref_regs[rs1];
  b         = use_imm ? imm : ref_regs[rs2];
  sum       = a + b;
  reads_rs2 = !use_imm || (op == core_pkg::op_store);
  // A source that waits on the load one stage ahead costs one cycle.
  stall = 0;
  if ((last_load_rd != 0) && (last_mem_cycle == issue_cycle + 1) &&
      ((rs1 == last_load_rd) || (reads_rs2 && (rs2 == last_load_rd)))) begin
    stall = 1;
  end
  if (op == core_pkg::op_load) begin
    value = ref_mem[sum[10:3]];
  end else if (op == core_pkg::op_store) begin
    value = sum;
    ref_mem[sum[10:3]] = ref_regs[rs2];
  end else begin
    value = alu_value(op, a, b);
  end
  writes = (rd != 0) && (op != core_pkg::op_store);
  if (writes) begin
    ref_regs[rd] = value;
  end
  exp_rd_q.push_back(rd);
  exp_we_q.push_back(writes);
  exp_data_q.push_back(value);
  exp_cycle_q.push_back(issue_cycle + 3 + stall);
  exp_stalls     = exp_stalls + stall;
  last_mem_cycle = issue_cycle + 2 + stall;
  last_load_rd   = (op == core_pkg::op_load) ? rd : '0;
endtask

`endif

// File: test/tb_exec_pipe.sv
// Execution pipeline testbench
`timescale 1ns/10ps

module tb_exec_pipe;

  localparam time clk_period  = 100ns;
  localparam int  drain_limit = 20;
  localparam int  n_alu  = 16;
  localparam int  n_fwd  = 16;
  localparam int  n_mem  = 12;
  localparam int  n_lu   = 18;
  localparam int  n_zero = 6;
  localparam int  n_rand = 400;
  // At most three cycles per instruction, counting a stall and an idle gap.
  localparam int  est_cycles = 8 + 6 * drain_limit
                               + 3 * (n_alu + n_fwd + n_mem + n_lu + n_zero + n_rand);

  logic                clk;
  logic                arst_n;
  logic                issue;
  core_pkg::alu_op_t   issue_op;
  core_pkg::reg_addr_t issue_rd;
  core_pkg::reg_addr_t issue_rs1;
  core_pkg::reg_addr_t issue_rs2;
  core_pkg::reg_t      issue_imm;
  logic                issue_use_imm;
  logic                issue_stall;
  logic                retire;
  logic                retire_we;
  core_pkg::reg_addr_t retire_rd;
  core_pkg::reg_t      retire_data;

  int             cycle_cnt;
  int             errors;
  int             errors_at_start;
  int             checks;
  int             stalls_seen;
  int             tests_run;
  int             tests_failed;
  core_pkg::reg_t mem_addrs [6];

  `include "tb_model.svh"

  exec_pipe DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue         (issue),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .issue_stall   (issue_stall),
    .retire        (retire),
    .retire_we     (retire_we),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_value(input string name, input core_pkg::reg_t exp,
                              input core_pkg::reg_t got);
    $display("FAILED %s expected %0h got %0h", name, exp, got);
    errors++;
  endtask

  task automatic check_retire();
    core_pkg::reg_addr_t e_rd;
    logic                e_we;
    core_pkg::reg_t      e_data;
    int                  e_cycle;
    checks++;
    assert (exp_rd_q.size() > 0) else begin
      $display("A retire came at cycle %0d with no instruction outstanding", cycle_cnt);
      errors++;
    end
    if (exp_rd_q.size() > 0) begin
      e_rd    = exp_rd_q.pop_front();
      e_we    = exp_we_q.pop_front();
      e_data  = exp_data_q.pop_front();
      e_cycle = exp_cycle_q.pop_front();
      assert (retire_rd == e_rd) else report_value("retire_rd", e_rd, retire_rd);
      assert (retire_we == e_we) else report_value("retire_we", e_we, retire_we);
      if (e_we) begin
        assert (retire_data == e_data) else report_value("retire_data", e_data, retire_data);
      end
      assert (cycle_cnt == e_cycle) else begin
        $display("Retire of x%0d came at cycle %0d instead of %0d", e_rd, cycle_cnt, e_cycle);
        errors++;
      end
    end
  endtask

  // Outputs change on the rising edge and are sampled on the falling edge.
  always @(negedge clk) begin
    if (!arst_n) begin
      assert (!retire) else report_value("retire", 0, retire);
      assert (!issue_stall) else report_value("issue_stall", 0, issue_stall);
    end else begin
      if (issue_stall) begin
        stalls_seen++;
      end
      if (retire) begin
        check_retire();
      end
    end
  end

  task automatic issue_instr(
    input core_pkg::alu_op_t   op,
    input core_pkg::reg_addr_t rd,
    input core_pkg::reg_addr_t rs1,
    input core_pkg::reg_addr_t rs2,
    input core_pkg::reg_t      imm,
    input logic                use_imm
  );
    @(negedge clk);
    issue = 1'b0;
    while (issue_stall) begin
      @(negedge clk);
    end
    issue         = 1'b1;
    issue_op      = op;
    issue_rd      = rd;
    issue_rs1     = rs1;
    issue_rs2     = rs2;
    issue_imm     = imm;
    issue_use_imm = use_imm;
    predict_retire(op, rd, rs1, rs2, imm, use_imm, cycle_cnt);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    issue = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    idle_cycle();
    while ((exp_rd_q.size() > 0) && (n < drain_limit)) begin
      @(negedge clk);
      n++;
    end
    assert (exp_rd_q.size() == 0) else begin
      $display("%0d instructions never retired", exp_rd_q.size());
      errors++;
    end
    assert (stalls_seen == exp_stalls) else begin
      $display("Saw %0d stall cycles where %0d were due", stalls_seen, exp_stalls);
      errors++;
    end
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_at_start);
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  function automatic core_pkg::reg_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic core_pkg::alu_op_t rand_alu_op();
    return core_pkg::alu_op_t'($urandom_range(0, 7));
  endfunction

  // Sources are written at least three slots earlier, so nothing is forwarded.
  task automatic alu_results_test();
    for (int i = 1; i <= 6; i++) begin
      issue_instr(core_pkg::op_add, i, 0, 0, rand64(), 1'b1);
    end
    for (int i = 0; i < n_alu - 6; i++) begin
      issue_instr(rand_alu_op(), 10 + i, $urandom_range(1, 3), $urandom_range(1, 3),
                  rand64(), $urandom_range(0, 1));
    end
    finish_test("alu results");
  endtask

  // rs1 comes from the previous instruction and rs2 from the one before it.
  task automatic forwarding_test();
    for (int i = 0; i < n_fwd; i++) begin
      issue_instr(rand_alu_op(), 1 + i % 4, 1 + (i + 3) % 4, 1 + (i + 2) % 4, '0, 1'b0);
    end
    finish_test("forwarding");
  endtask

  task automatic memory_test();
    for (int i = 0; i < 6; i++) begin
      mem_addrs[i] = $urandom_range(0, 255) * 8;
      issue_instr(core_pkg::op_store, 20 + i, 0, 1 + i % 4, mem_addrs[i], 1'b1);
    end
    for (int i = 0; i < 6; i++) begin
      issue_instr(core_pkg::op_load, 20 + i, 0, 0, mem_addrs[i], 1'b1);
    end
    finish_test("memory access");
  endtask

  task automatic load_use_test();
    for (int i = 0; i < 3; i++) begin
      issue_instr(core_pkg::op_load, 5, 0, 0, mem_addrs[i], 1'b1);
      issue_instr(core_pkg::op_add, 6, 5, 1, '0, 1'b0);
      issue_instr(core_pkg::op_load, 7, 0, 0, mem_addrs[i + 1], 1'b1);
      issue_instr(core_pkg::op_xor, 9, 2, 3, '0, 1'b0);
      issue_instr(core_pkg::op_sub, 8, 7, 6, '0, 1'b0);
      issue_instr(core_pkg::op_store, 0, 0, 8, mem_addrs[5 - i], 1'b1);
    end
    finish_test("load-use stall");
  endtask

  task automatic reg_zero_test();
    issue_instr(core_pkg::op_add, 0, 1, 2, '0, 1'b0);
    issue_instr(core_pkg::op_or, 11, 0, 0, '0, 1'b0);
    issue_instr(core_pkg::op_load, 0, 0, 0, mem_addrs[0], 1'b1);
    issue_instr(core_pkg::op_add, 12, 0, 3, '0, 1'b0);
    issue_instr(core_pkg::op_xor, 0, 4, 3, '0, 1'b0);
    issue_instr(core_pkg::op_sub, 13, 3, 0, '0, 1'b0);
    finish_test("register zero");
  endtask

  task automatic random_test();
    core_pkg::alu_op_t op;
    logic              mem_op;
    core_pkg::reg_t    imm;
    for (int i = 0; i < n_rand; i++) begin
      if ($urandom_range(0, 7) == 0) begin
        idle_cycle();
      end
      op     = core_pkg::alu_op_t'($urandom_range(0, 9));
      mem_op = (op == core_pkg::op_load) || (op == core_pkg::op_store);
      imm    = mem_op ? core_pkg::reg_t'($urandom_range(0, 2047)) : rand64();
      issue_instr(op, $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7),
                  imm, mem_op || ($urandom_range(0, 1) == 1));
    end
    finish_test("long random run");
  endtask

  initial begin
    void'($urandom(32'hfb4f));
    arst_n          = 1'b0;
    issue           = 1'b0;
    issue_op        = core_pkg::op_add;
    issue_rd        = '0;
    issue_rs1       = '0;
    issue_rs2       = '0;
    issue_imm       = '0;
    issue_use_imm   = 1'b0;
    cycle_cnt       = 0;
    errors          = 0;
    errors_at_start = 0;
    checks          = 0;
    stalls_seen     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    reset_model();
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    alu_results_test();
    forwarding_test();
    memory_test();
    load_use_test();
    reg_zero_test();
    random_test();
    $display("%0d tests run, %0d failed, %0d retires checked, %0d errors",
             tests_run, tests_failed, checks, errors);
    if ((tests_failed == 0) && (errors == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(4 * est_cycles * clk_period);
    $display("Timeout after %0d cycles with the tests still running", 4 * est_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+test
common/core_pkg.sv
logic/reg_file.sv
logic/data_ram.sv
pipe/forward.sv
pipe/alu.sv
pipe/exec_stage.sv
pipe/mem_stage.sv
pipe/exec_pipe.sv
test/tb_exec_pipe.sv
